//--- common/busPkg.sv
// Local bus definitions shared by the ports, arbiter, decoder and top
package busPkg;

	//////////////////////////////
	// Bus sizing
	//////////////////////////////

	// Two masters share the local bus, CPU side and bridge DMA side
	localparam int numMasters = 2;
	// Queue slots per port, also the credits each master starts with
	localparam int portDepth = 2;
	localparam int tagWidth = 4;
	// Queue pointer and fill count widths
	localparam int portPtrWidth = $clog2(portDepth);
	localparam int portCountWidth = $clog2(portDepth + 1);

	//////////////////////////////
	// Address map
	//////////////////////////////

	// Pages are addr 23..16 of the 24-bit low space
	localparam logic [7:0] ciaPage = 8'hBF;
	localparam logic [7:0] rtcPage = 8'hDC;
	localparam logic [7:0] chipRegPage = 8'hDF;
	// Zorro II autoconfig window
	localparam logic [7:0] autoconfigPage = 8'hE8;

	// On-board resource hit by an access
	typedef enum logic [3:0] {
		regNone,
		regRom,
		regChipRam,
		regCia,
		regRtc,
		regChipReg,
		regAutoconfig,
		regBridge,
		regZ3Ram
	} busRegion;

	//////////////////////////////
	// Bus records
	//////////////////////////////

	// One request from a master, address only down to the 4K page bit
	typedef struct packed {
		logic valid;
		logic [31:12] addr;
		logic write;
		logic [tagWidth-1:0] tag;
	} busRequest;

	// Static decode settings from autoconfig and the overlay latch
	typedef struct packed {
		logic overlay;
		logic configured;
		logic ciaEnable;
		// Compared with addr 31..29
		logic [2:0] bridgeBase;
		// Compared with addr 31..28
		logic [3:0] ramBase;
	} decodeConfig;

	// Completion record, one cycle pulse
	typedef struct packed {
		logic valid;
		logic master;
		logic [tagWidth-1:0] tag;
		busRegion region;
		// Active high, bit 0 is CS0
		logic [1:0] ciaSel;
		logic write;
	} busResponse;

endpackage

//--- common/cyclePkg.sv
// Chipset register cycle definitions
package cyclePkg;

	//////////////////////////////
	// Register cycle FSM
	//////////////////////////////

	// Emulated MC68000 cycle steps
	typedef enum logic [1:0] {
		// Nothing pending
		rcIdle,
		// Waiting for the next CLK7 rise, state 2 of the 68000 cycle
		rcWaitRise,
		// Enable asserted, counting CLK7 falls
		rcActive,
		// One cycle of completion
		rcDone
	} regCycleState;

	//////////////////////////////
	// CLK7 edge counts
	//////////////////////////////

	// Falls counted before the cycle ends, lands on the fall of state 6
	localparam int regFallCount = 2;
	localparam int fallCountWidth = 2;

endpackage

//--- rtl/requestPort.sv
`timescale 1ns/1ps

// Request queue of one bus master
module requestPort (
	input  logic CLK40,
	input  logic nRESET,
	input  busPkg::busRequest req,
	input  logic pop,
	input  logic done,
	output busPkg::busRequest head,
	output logic creditRet
);

	import busPkg::*;

	// Queue storage
	busRequest slots [portDepth];
	logic [portPtrWidth-1:0] wrPtr;
	logic [portPtrWidth-1:0] rdPtr;
	logic [portCountWidth-1:0] fill;

	//////////////////////////////
	// Queue pointers
	//////////////////////////////

	// Credits guarantee a free slot, so a valid request is always taken
	always_ff @(posedge CLK40 or negedge nRESET) begin
		if (!nRESET) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			creditRet <= 1'b0;
		end else begin
			if (req.valid) begin
				// Wrap at the last slot
				if (wrPtr == portPtrWidth'(portDepth - 1)) begin
					wrPtr <= '0;
				end else begin
					wrPtr <= wrPtr + 1'b1;
				end
			end
			if (pop) begin
				if (rdPtr == portPtrWidth'(portDepth - 1)) begin
					rdPtr <= '0;
				end else begin
					rdPtr <= rdPtr + 1'b1;
				end
			end
			// Push and pop in one cycle leave the fill unchanged
			if (req.valid && !pop) begin
				fill <= fill + 1'b1;
			end else if (pop && !req.valid) begin
				fill <= fill - 1'b1;
			end
			// Completion of our access hands a credit back to the master
			creditRet <= done;
		end
	end

	// Slot write
	always_ff @(posedge CLK40) begin
		if (req.valid) begin
			slots[wrPtr] <= req;
		end
	end

	//////////////////////////////
	// Head
	//////////////////////////////

	// Oldest entry is valid whenever something is queued
	always_comb begin
		head = slots[rdPtr];
		head.valid = (fill != '0);
	end

endmodule

//--- rtl/busArbiter.sv
`timescale 1ns/1ps

// Round-robin owner of the shared local bus
module busArbiter (
	input  logic CLK40,
	input  logic nRESET,
	input  busPkg::busRequest heads [busPkg::numMasters],
	input  busPkg::busRegion region,
	input  logic [1:0] ciaSel,
	input  logic regDone,
	output logic [busPkg::numMasters-1:0] pop,
	output logic [busPkg::numMasters-1:0] done,
	output logic [31:12] grantAddr,
	output logic regStart,
	output busPkg::busResponse rsp
);

	import busPkg::*;

	// Control
	logic busy;
	// Winner of the last grant, also the owner of the bus while busy
	logic lastWinner;
	logic pick;
	logic grant;
	logic finish;
	logic rspValid;
	// Captured access
	logic [31:12] curAddr;
	logic curWrite;
	logic [tagWidth-1:0] curTag;
	busRegion curRegion;
	logic [1:0] curCiaSel;

	//////////////////////////////
	// Grant selection
	//////////////////////////////

	// Contention goes to the master that lost last time
	always_comb begin
		if (heads[0].valid && heads[1].valid) begin
			pick = ~lastWinner;
		end else begin
			pick = heads[1].valid;
		end
	end

	assign grant = !busy && (heads[0].valid || heads[1].valid);
	// Decoder looks at the candidate while idle so the region is ready at grant
	assign grantAddr = busy ? curAddr : heads[pick].addr;

	always_comb begin
		pop = '0;
		if (grant) begin
			pop[pick] = 1'b1;
		end
	end

	//////////////////////////////
	// Completion
	//////////////////////////////

	// Register accesses wait for the 68000 cycle, everything else is one cycle
	assign finish = busy && ((curRegion != regChipReg) || regDone);

	always_comb begin
		done = '0;
		if (finish) begin
			done[lastWinner] = 1'b1;
		end
	end

	always_ff @(posedge CLK40 or negedge nRESET) begin
		if (!nRESET) begin
			busy <= 1'b0;
			// Master 0 wins the first contention
			lastWinner <= 1'b1;
			regStart <= 1'b0;
			rspValid <= 1'b0;
		end else begin
			regStart <= grant && (region == regChipReg);
			rspValid <= finish;
			if (grant) begin
				busy <= 1'b1;
				lastWinner <= pick;
			end else if (finish) begin
				busy <= 1'b0;
			end
		end
	end

	// Held until the next grant, which is after the response cycle
	always_ff @(posedge CLK40) begin
		if (grant) begin
			curAddr <= heads[pick].addr;
			curWrite <= heads[pick].write;
			curTag <= heads[pick].tag;
			curRegion <= region;
			curCiaSel <= ciaSel;
		end
	end

	assign rsp = '{valid: rspValid, master: lastWinner, tag: curTag, region: curRegion,
		ciaSel: curCiaSel, write: curWrite};

endmodule

//--- decode/addressDecode.sv
`timescale 1ns/1ps

// Region decode of the granted address
module addressDecode (
	input  logic [31:12] addr,
	input  busPkg::decodeConfig cfg,
	output busPkg::busRegion region,
	output logic [1:0] ciaSel
);

	import busPkg::*;

	logic z3Space;
	logic [7:0] page;
	logic lowSpace;
	logic romHigh;
	logic bridgeHit;
	logic ramHit;

	//////////////////////////////
	// Zorro III space
	//////////////////////////////

	// Anything above the 24-bit space
	assign z3Space = addr[31:24] != 8'h00;

	// Bridge window and Z3 RAM only exist once autoconfig is done
	assign bridgeHit = cfg.configured && (addr[31:29] == cfg.bridgeBase);
	assign ramHit = cfg.configured && (addr[31:28] == cfg.ramBase);

	//////////////////////////////
	// 24-bit space
	//////////////////////////////

	// 64K page select
	assign page = addr[23:16];
	// $00 0000 to $1F FFFF, ROM under overlay and chip RAM after
	assign lowSpace = addr[23:21] == 3'b000;
	// $F8 0000 to $FF FFFF
	assign romHigh = addr[23:19] == 5'b11111;

	//////////////////////////////
	// Priority decode
	//////////////////////////////

	always_comb begin
		region = regNone;
		ciaSel = 2'b00;
		if (z3Space) begin
			// Bridge wins when both bases match
			if (bridgeHit) begin
				region = regBridge;
			end else if (ramHit) begin
				region = regZ3Ram;
			end
		end else if (lowSpace) begin
			// Reset vector fetches come from ROM while overlay is set
			if (cfg.overlay) begin
				region = regRom;
			end else begin
				region = regChipRam;
			end
		end else if (!cfg.overlay && romHigh) begin
			region = regRom;
		end else begin
			case (page)
				ciaPage: begin
					// CIA space is dead while the CIAs are disabled
					if (cfg.ciaEnable) begin
						region = regCia;
						ciaSel = {addr[13], addr[12]};
					end
				end
				rtcPage: region = regRtc;
				// Agnus and friends, needs the 68000 style cycle
				chipRegPage: region = regChipReg;
				autoconfigPage: region = regAutoconfig;
				default: region = regNone;
			endcase
		end
	end

endmodule

//--- decode/registerCycle.sv
`timescale 1ns/1ps

// MC68000 compatible cycle for the chipset registers
module registerCycle (
	input  logic CLK40,
	input  logic nRESET,
	input  logic CLK7,
	input  logic regStart,
	output logic nRegEn,
	output logic regDone
);

	import cyclePkg::*;

	regCycleState state;
	// Bit 0 is the newest CLK7 sample
	logic [1:0] clk7Shift;
	logic clk7Rise;
	logic clk7Fall;
	logic [fallCountWidth-1:0] fallCount;

	//////////////////////////////
	// CLK7 edge detect
	//////////////////////////////

	always_ff @(posedge CLK40 or negedge nRESET) begin
		if (!nRESET) begin
			clk7Shift <= 2'b11;
		end else begin
			clk7Shift <= {clk7Shift[0], CLK7};
		end
	end

	assign clk7Rise = clk7Shift == 2'b01;
	assign clk7Fall = clk7Shift == 2'b10;

	//////////////////////////////
	// Register cycle FSM
	//////////////////////////////

	// Enable goes low on a CLK7 rise so the cycle starts as early as possible
	// The CPU side raises its strobes in response, we only count edges here
	always_ff @(posedge CLK40 or negedge nRESET) begin
		if (!nRESET) begin
			state <= rcIdle;
			nRegEn <= 1'b1;
			regDone <= 1'b0;
			fallCount <= '0;
		end else begin
			// Done is a single cycle pulse
			regDone <= 1'b0;
			unique case (state)
				rcIdle: begin
					if (regStart) begin
						state <= rcWaitRise;
					end
				end
				rcWaitRise: begin
					if (clk7Rise) begin
						nRegEn <= 1'b0;
						fallCount <= '0;
						state <= rcActive;
					end
				end
				rcActive: begin
					// End on the last counted fall
					if (clk7Fall) begin
						if (fallCount == fallCountWidth'(regFallCount - 1)) begin
							nRegEn <= 1'b1;
							regDone <= 1'b1;
							state <= rcDone;
						end else begin
							fallCount <= fallCount + 1'b1;
						end
					end
				end
				rcDone: state <= rcIdle;
				default: state <= rcIdle;
			endcase
		end
	end

endmodule

//--- rtl/localBusTop.sv
`timescale 1ns/1ps

// Local bus front end, two masters onto the on-board resources
module localBusTop (
	input  logic CLK40,
	input  logic nRESET,
	input  logic CLK7,
	input  busPkg::decodeConfig cfg,
	input  busPkg::busRequest req [busPkg::numMasters],
	output logic [busPkg::numMasters-1:0] creditRet,
	output busPkg::busResponse rsp,
	output logic nRegEn
);

	import busPkg::*;

	// Port to arbiter
	busRequest heads [numMasters];
	logic [numMasters-1:0] pop;
	logic [numMasters-1:0] done;
	// Arbiter to decoder
	logic [31:12] grantAddr;
	busRegion region;
	logic [1:0] ciaSel;
	// Arbiter to register cycle
	logic regStart;
	logic regDone;

	//////////////////////////////
	// Master ports
	//////////////////////////////

	// Master 0 is the CPU side, master 1 the bridge DMA
	for (genvar m = 0; m < numMasters; m++) begin : gPort
		requestPort port (
			.CLK40     (CLK40),
			.nRESET    (nRESET),
			.req       (req[m]),
			.pop       (pop[m]),
			.done      (done[m]),
			.head      (heads[m]),
			.creditRet (creditRet[m])
		);
	end

	//////////////////////////////
	// Bus ownership and decode
	//////////////////////////////

	busArbiter arbiter (
		.CLK40     (CLK40),
		.nRESET    (nRESET),
		.heads     (heads),
		.region    (region),
		.ciaSel    (ciaSel),
		.regDone   (regDone),
		.pop       (pop),
		.done      (done),
		.grantAddr (grantAddr),
		.regStart  (regStart),
		.rsp       (rsp)
	);

	addressDecode decoder (
		.addr   (grantAddr),
		.cfg    (cfg),
		.region (region),
		.ciaSel (ciaSel)
	);

	// Chipset registers run on CLK7 timing
	registerCycle regCycle (
		.CLK40    (CLK40),
		.nRESET   (nRESET),
		.CLK7     (CLK7),
		.regStart (regStart),
		.nRegEn   (nRegEn),
		.regDone  (regDone)
	);

endmodule

//--- sim/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//////////////////////////////
// Error counters
//////////////////////////////

// Wrong values
int errorCount = 0;
// Timeouts and protocol slips
int failCount = 0;

task automatic checkRegion(input string name, input busRegion expected, input busRegion actual);
	if (actual !== expected) begin
		errorCount++;
		$display("ERR %0t %s expected %s got %s", $time, name, expected.name(), actual.name());
	end
endtask

// Owner, tag and direction of a response
task automatic checkResp(input string name, input busResponse expected, input busResponse actual);
	if (actual.master !== expected.master) begin
		errorCount++;
		$display("ERR %0t %s.master expected %0d got %0d", $time, name, expected.master,
			actual.master);
	end
	if (actual.tag !== expected.tag) begin
		errorCount++;
		$display("ERR %0t %s.tag expected %h got %h", $time, name, expected.tag, actual.tag);
	end
	if (actual.write !== expected.write) begin
		errorCount++;
		$display("ERR %0t %s.write expected %b got %b", $time, name, expected.write,
			actual.write);
	end
endtask

task automatic checkBits(input string name, input logic [1:0] expected, input logic [1:0] actual);
	if (actual !== expected) begin
		errorCount++;
		$display("ERR %0t %s expected %b got %b", $time, name, expected, actual);
	end
endtask

task automatic checkCount(input string name, input int expected, input int actual);
	if (actual != expected) begin
		errorCount++;
		$display("ERR %0t %s expected %0d got %0d", $time, name, expected, actual);
	end
endtask

task automatic reportFailure(input string what);
	failCount++;
	$display("%0t %s", $time, what);
endtask

`endif

//--- sim/tbLocalBus.sv
`timescale 1ns/1ps

// Directed testbench of the local bus front end
module tbLocalBus;

	import busPkg::*;
	import cyclePkg::*;

	localparam int driveDelay = 10;
	localparam int timeoutCycles = 200;
	// Cycles from issue edge to response edge through queue, grant and response
	localparam int fastLatency = 3;

	// One response as the monitor saw it
	typedef struct packed {
		busResponse rsp;
		logic [1:0] credit;
		logic regEn;
		logic [31:0] edgeNum;
	} rspRecord;

	logic CLK40;
	logic CLK7;
	logic nRESET;
	decodeConfig cfg;
	busRequest req [numMasters];
	logic [numMasters-1:0] creditRet;
	busResponse rsp;
	logic nRegEn;

	// Model state
	int edgeCount = 0;
	int credits [numMasters];
	int creditPulses [numMasters];
	int lastMaster;
	logic [tagWidth-1:0] nextTag;
	logic regEnLowSeen;
	rspRecord rspQueue [$];

	`include "tbChecks.svh"

	localBusTop UUT (
		.CLK40     (CLK40),
		.nRESET    (nRESET),
		.CLK7      (CLK7),
		.cfg       (cfg),
		.req       (req),
		.creditRet (creditRet),
		.rsp       (rsp),
		.nRegEn    (nRegEn)
	);

	//////////////////////////////
	// Clocks and monitor
	//////////////////////////////

	initial begin
		CLK40 = 1'b0;
		forever #50 CLK40 = ~CLK40;
	end

	// Roughly 5.7 CLK40 cycles per CLK7 cycle
	initial begin
		CLK7 = 1'b0;
		forever #285 CLK7 = ~CLK7;
	end

	always @(posedge CLK40) begin
		edgeCount <= edgeCount + 1;
	end

	// Outputs are settled at the falling edge
	always @(negedge CLK40) begin
		if (nRESET) begin
			for (int m = 0; m < numMasters; m++) begin
				if (creditRet[m]) begin
					credits[m]++;
					creditPulses[m]++;
				end
			end
			if (!nRegEn) begin
				regEnLowSeen = 1'b1;
			end
			if (rsp.valid) begin
				rspQueue.push_back(rspRecord'{rsp: rsp, credit: creditRet, regEn: nRegEn,
					edgeNum: edgeCount});
			end
		end
	end

	//////////////////////////////
	// Drivers
	//////////////////////////////

	task automatic stepCycle();
		@(posedge CLK40);
		#driveDelay;
	endtask

	task automatic setConfig(input logic overlay, input logic configured, input logic ciaEnable,
		input logic [2:0] bridgeBase, input logic [3:0] ramBase);
		cfg.overlay = overlay;
		cfg.configured = configured;
		cfg.ciaEnable = ciaEnable;
		cfg.bridgeBase = bridgeBase;
		cfg.ramBase = ramBase;
	endtask

	// Takes one credit and leaves ending the pulse to the caller
	task automatic sendRequest(input int m, input logic [31:12] addr, input logic [3:0] tag);
		if (credits[m] == 0) begin
			reportFailure($sformatf("master %0d sent tag %h without a credit", m, tag));
		end else begin
			credits[m]--;
		end
		req[m] = busRequest'{valid: 1'b1, addr: addr, write: tag[0], tag: tag};
	endtask

	task automatic clearRequests();
		for (int m = 0; m < numMasters; m++) begin
			req[m].valid = 1'b0;
		end
	endtask

	task automatic waitResponse(output rspRecord rec, output bit got);
		int waited;
		waited = 0;
		rec = '0;
		while (rspQueue.size() == 0 && waited < timeoutCycles) begin
			stepCycle();
			waited++;
		end
		got = rspQueue.size() != 0;
		if (got) begin
			rec = rspQueue.pop_front();
		end else begin
			reportFailure("no response within timeout");
		end
	endtask

	// Expected region from the address map
	function automatic busRegion modelRegion(input logic [31:12] a, input decodeConfig c,
		output logic [1:0] sel);
		sel = 2'b00;
		// Zorro III space with the bridge ahead of RAM
		if (a[31:24] != 8'h00) begin
			if (c.configured && a[31:29] == c.bridgeBase) return regBridge;
			if (c.configured && a[31:28] == c.ramBase) return regZ3Ram;
			return regNone;
		end
		if (a[23:21] == 3'b000) return c.overlay ? regRom : regChipRam;
		if (!c.overlay && a[23:19] == 5'b11111) return regRom;
		if (a[23:16] == 8'hBF) begin
			if (!c.ciaEnable) return regNone;
			sel = {a[13], a[12]};
			return regCia;
		end
		if (a[23:16] == 8'hDC) return regRtc;
		if (a[23:16] == 8'hDF) return regChipReg;
		if (a[23:16] == 8'hE8) return regAutoconfig;
		return regNone;
	endfunction

	// One access with latency -1 when nothing came back
	task automatic singleAccess(input int m, input logic [31:12] addr, output rspRecord rec,
		output int latency);
		busRegion expRegion;
		logic [1:0] expSel;
		busResponse expRsp;
		int issueEdge;
		bit got;
		expRegion = modelRegion(addr, cfg, expSel);
		issueEdge = edgeCount;
		sendRequest(m, addr, nextTag);
		stepCycle();
		clearRequests();
		waitResponse(rec, got);
		latency = got ? int'(rec.edgeNum) - issueEdge : -1;
		if (got) begin
			expRsp = '0;
			expRsp.master = m[0];
			expRsp.tag = nextTag;
			expRsp.write = nextTag[0];
			checkResp("rsp", expRsp, rec.rsp);
			checkRegion("rsp.region", expRegion, rec.rsp.region);
			checkBits("rsp.ciaSel", expSel, rec.rsp.ciaSel);
			if (expRegion != regChipReg) begin
				checkCount("latency", fastLatency, latency);
			end
		end
		lastMaster = m;
		nextTag++;
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic lowSpaceTest();
		logic [7:0] pages [6];
		rspRecord rec;
		int latency;
		pages = '{8'h00, 8'hF8, 8'hBF, 8'hDC, 8'hE8, 8'h50};
		// Overlay first as after reset
		for (int ov = 1; ov >= 0; ov--) begin
			setConfig(ov[0], 1'b0, 1'b1, 3'b010, 4'h8);
			foreach (pages[i]) begin
				singleAccess(0, {8'h00, pages[i], 4'($urandom)}, rec, latency);
			end
		end
	endtask

	task automatic z3Test();
		rspRecord rec;
		int latency;
		// Both windows stay dead until configured
		for (int conf = 0; conf < 2; conf++) begin
			setConfig(1'b0, conf[0], 1'b1, 3'b010, 4'h8);
			singleAccess(0, {4'h4, 16'($urandom)}, rec, latency);
			singleAccess(0, {4'h8, 16'($urandom)}, rec, latency);
		end
		// Both bases hit
		setConfig(1'b0, 1'b1, 1'b1, 3'b100, 4'h8);
		singleAccess(0, {4'h8, 16'($urandom)}, rec, latency);
	endtask

	task automatic ciaTest();
		rspRecord rec;
		int latency;
		setConfig(1'b0, 1'b1, 1'b1, 3'b010, 4'h8);
		for (int s = 0; s < 4; s++) begin
			singleAccess(0, {8'h00, 8'hBF, 2'($urandom), s[1], s[0]}, rec, latency);
		end
		// CIAs disabled
		setConfig(1'b0, 1'b1, 1'b0, 3'b010, 4'h8);
		singleAccess(0, {8'h00, 8'hBF, 2'($urandom), 2'b11}, rec, latency);
	endtask

	task automatic registerTest();
		rspRecord rec;
		int latency;
		// A CLK7 period spans at least five CLK40 cycles
		int minLatency = fastLatency + (regFallCount - 1) * 5;
		setConfig(1'b0, 1'b1, 1'b1, 3'b010, 4'h8);
		regEnLowSeen = 1'b0;
		singleAccess(0, {8'h00, 8'hDF, 4'($urandom)}, rec, latency);
		if (latency >= 0) begin
			if (!regEnLowSeen) begin
				reportFailure("nRegEn never went low before the register response");
			end
			checkBits("nRegEn", 2'b01, {1'b0, rec.regEn});
			if (latency < minLatency) begin
				reportFailure($sformatf("register cycle ended after only %0d cycles", latency));
			end
		end
	endtask

	task automatic creditTest();
		rspRecord rec;
		bit got;
		busResponse expRsp;
		int pulsesBefore;
		logic [tagWidth-1:0] firstTag;
		firstTag = nextTag;
		pulsesBefore = creditPulses[1];
		for (int i = 0; i < portDepth; i++) begin
			sendRequest(1, {8'h00, 8'hDC, 4'($urandom)}, nextTag);
			nextTag++;
			stepCycle();
		end
		clearRequests();
		checkCount("credits[1]", 0, credits[1]);
		for (int i = 0; i < portDepth; i++) begin
			waitResponse(rec, got);
			if (got) begin
				expRsp = '0;
				expRsp.master = 1'b1;
				expRsp.tag = firstTag + i;
				expRsp.write = expRsp.tag[0];
				checkResp("rsp", expRsp, rec.rsp);
				checkBits("creditRet", 2'b10, rec.credit);
			end
		end
		checkCount("creditRet pulses", portDepth, creditPulses[1] - pulsesBefore);
		lastMaster = 1;
	endtask

	task automatic arbitrationTest();
		rspRecord rec;
		bit got;
		busResponse expRsp;
		int first;
		int em;
		logic [tagWidth-1:0] baseTag;
		baseTag = nextTag;
		// Rotation favors the master that did not win last
		first = 1 - lastMaster;
		// Request i of master m carries baseTag + 2m + i
		for (int i = 0; i < 2; i++) begin
			sendRequest(0, {8'h00, 8'hDC, 4'($urandom)}, baseTag + i);
			sendRequest(1, {8'h00, 8'hE8, 4'($urandom)}, baseTag + 2 + i);
			stepCycle();
		end
		clearRequests();
		for (int k = 0; k < 4; k++) begin
			waitResponse(rec, got);
			if (got) begin
				em = (first + k) % 2;
				expRsp = '0;
				expRsp.master = em[0];
				expRsp.tag = baseTag + 2 * em + k / 2;
				expRsp.write = expRsp.tag[0];
				checkResp("rsp", expRsp, rec.rsp);
			end
		end
		lastMaster = (first + 3) % 2;
		nextTag = baseTag + 4;
	endtask

	//////////////////////////////
	// Main flow
	//////////////////////////////

	initial begin : mainFlow
		void'($urandom(11));
		nRESET = 1'b0;
		cfg = '0;
		nextTag = '0;
		regEnLowSeen = 1'b0;
		lastMaster = 1;
		for (int m = 0; m < numMasters; m++) begin
			req[m] = '0;
			credits[m] = portDepth;
			creditPulses[m] = 0;
		end
		repeat (5) @(posedge CLK40);
		#driveDelay;
		nRESET = 1'b1;
		stepCycle();
		lowSpaceTest();
		z3Test();
		ciaTest();
		registerTest();
		creditTest();
		arbitrationTest();
		// Every credit is back home
		for (int m = 0; m < numMasters; m++) begin
			checkCount($sformatf("credits[%0d]", m), portDepth, credits[m]);
		end
		$display("Errors: %0d mismatches, %0d other failures", errorCount, failCount);
		if (errorCount == 0 && failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+sim
common/busPkg.sv
common/cyclePkg.sv
rtl/requestPort.sv
rtl/busArbiter.sv
decode/addressDecode.sv
decode/registerCycle.sv
rtl/localBusTop.sv
sim/tbLocalBus.sv
